// ==== tb.f ====
rtl/gtePkg.sv
rtl/GTEOverflowFLAGS.sv
rtl/gteMacAccumulator.sv
rtl/gteFieldLimiter.sv
rtl/gteFlagWriter.sv
rtl/gteMacStage.sv
bench/gteMacStageTb.sv

// ==== Makefile ====
# Verilator build for the MAC lane testbench

VERILATOR ?= verilator
TOP       ?= gteMacStageTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

// ==== bench/gteMacStageTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gteMacStageTb;

	logic clk;
	logic rstN;
	logic opValid;
	logic signed [gtePkg::OperandW-1:0] opA;
	logic signed [gtePkg::OperandW-1:0] opB;
	logic accumulate;
	logic sf;
	logic lm;
	logic [gtePkg::LaneW-1:0] lane;
	logic flagClear;
	logic resultValid;
	logic [gtePkg::IrW-1:0]     resultIr;
	logic [gtePkg::ColorW-1:0]  resultColor;
	logic [gtePkg::ZW-1:0]      resultZ;
	logic [gtePkg::ScreenW-1:0] resultScreen;
	logic [gtePkg::Ir0W-1:0]    resultIr0;
	logic [31:0] flagWord;

	// Reference model state
	longint refAcc;			// Model accumulator
	logic [31:0] expFlags;	// Expected sticky FLAG word
	logic checking;
	logic clrAtEdge;		// flagClear as seen by the last edge
	int cyc;
	logic [15:0] lfsr;

	// Expected results in issue order
	logic [15:0] qIr[$];
	logic [7:0]  qColor[$];
	logic [15:0] qZ[$];
	logic [10:0] qScreen[$];
	logic [12:0] qIr0[$];
	logic [31:0] qBits[$];	// FLAG bits this op sets
	int qCyc[$];			// Issue cycle for latency

	initial clk = 1'b0;
	always #10 clk = ~clk;	// 20 ns period

	gteMacStage gteMacStage_i (
		.clk(clk), .rstN(rstN), .opValid(opValid), .opA(opA), .opB(opB),
		.accumulate(accumulate), .sf(sf), .lm(lm), .lane(lane), .flagClear(flagClear),
		.resultValid(resultValid), .resultIr(resultIr), .resultColor(resultColor),
		.resultZ(resultZ), .resultScreen(resultScreen), .resultIr0(resultIr0),
		.flagWord(flagWord)
	);

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic checkValue(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	// x^16 + x^14 + x^13 + x^11, one step per bit
	function automatic logic [15:0] randomBits(input int n);
		logic [15:0] r;
		logic fb;
		int i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r    = {r[14:0], fb};
		end
		return r;
	endfunction

	function automatic longint clampValue(input longint x, input longint lo, input longint hi);
		if (x < lo)
			return lo;
		if (x > hi)
			return hi;
		return x;
	endfunction

	// Drive one op and queue what the range rules predict
	task automatic driveOp(input logic signed [15:0] a, input logic signed [15:0] b,
		input logic accV, input logic sfV, input logic lmV, input logic [1:0] laneV);
		longint v, ir, col, scr, ir0, irLo;
		logic [31:0] bits;
		int sh;
		int idx;
		@(posedge clk);
		#1;
		opValid    = 1'b1;
		opA        = a;
		opB        = b;
		accumulate = accV;
		sf         = sfV;
		lm         = lmV;
		lane       = laneV;
		v      = (accV ? refAcc : 64'sd0) + longint'(a) * longint'(b);
		refAcc = v;
		sh   = sfV ? 12 : 0;
		irLo = lmV ? 0 : -32768;	// lm floors IR at zero
		ir   = v >>> sh;			// IR and Z share the shift
		col  = v >>> (sh + 4);
		scr  = v >>> 16;
		ir0  = v >>> 12;
		bits = '0;
		idx  = laneV;
		if (laneV == 2'd3) begin
			bits[16] = v > 64'sd2147483647;	// MAC0 31 bit range
			bits[15] = v < -64'sd2147483648;
			bits[12] = clampValue(ir0, 0, 4096) != ir0;
		end else begin
			bits[30-idx] = v > (longint'(1) <<< 42) - 1;	// MAC1..3 43 bit range
			bits[27-idx] = v < -(longint'(1) <<< 42);
			bits[24-idx] = clampValue(ir, irLo, 32767) != ir;
			bits[21-idx] = clampValue(col, 0, 255) != col;
			if (laneV == 2'd0)
				bits[14] = clampValue(scr, -1024, 1023) != scr;
			if (laneV == 2'd1)
				bits[13] = clampValue(scr, -1024, 1023) != scr;
			if (laneV == 2'd2)
				bits[18] = clampValue(ir, 0, 65535) != ir;	// OTZ
		end
		qIr.push_back(16'(clampValue(ir, irLo, 32767)));
		qColor.push_back(8'(clampValue(col, 0, 255)));
		qZ.push_back(16'(clampValue(ir, 0, 65535)));
		qScreen.push_back(11'(clampValue(scr, -1024, 1023)));
		qIr0.push_back(13'(clampValue(ir0, 0, 4096)));
		qBits.push_back(bits);
		qCyc.push_back(cyc);
	endtask

	// Stop driving, then drain every outstanding result
	task automatic waitIdle();
		int n;
		@(posedge clk);
		#1;
		opValid   = 1'b0;
		flagClear = 1'b0;
		n = 0;
		while (qIr.size() != 0) begin
			if (n == 20)
				abortRun("Timeout: resultValid did not arrive for every operation");
			@(posedge clk);
			#1;
			n++;
		end
	endtask

	task automatic clearFlags();
		@(posedge clk);
		#1;
		flagClear = 1'b1;
		@(posedge clk);
		#1;
		flagClear = 1'b0;
		checkValue("flagWord", 64'(flagWord), 64'd0);
	endtask

	// --------------------------------------------------
	// Result monitor
	// --------------------------------------------------
	always @(posedge clk) begin
		cyc       = cyc + 1;
		clrAtEdge = flagClear;
	end

	always @(negedge clk) begin
		if (checking) begin
			if (clrAtEdge)
				expFlags = '0;	// Old bits go, new ones still land
			if (resultValid) begin
				if (qIr.size() == 0)
					abortRun("Error: resultValid high with no operation outstanding");
				checkValue("resultIr", 64'(resultIr), 64'(qIr.pop_front()));
				checkValue("resultColor", 64'(resultColor), 64'(qColor.pop_front()));
				checkValue("resultZ", 64'(resultZ), 64'(qZ.pop_front()));
				checkValue("resultScreen", 64'(resultScreen), 64'(qScreen.pop_front()));
				checkValue("resultIr0", 64'(resultIr0), 64'(qIr0.pop_front()));
				checkValue("resultValid latency", 64'(cyc - qCyc.pop_front()), 64'd2);
				expFlags = expFlags | qBits.pop_front();
			end
			expFlags[31] = (|expFlags[30:23]) | (|expFlags[18:13]);	// Skips 22 and colour
			checkValue("flagWord", 64'(flagWord), 64'(expFlags));
		end
	end

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic checkResetAndLatency();
		int i;
		checkValue("flagWord", 64'(flagWord), 64'd0);
		checkValue("resultValid", 64'(resultValid), 64'd0);
		driveOp(16'sd100, 16'sd20, 1'b0, 1'b0, 1'b0, 2'd0);	// Lone op
		waitIdle();
		for (i = 0; i < 4; i++)	// Back to back, chained through the pipe
			driveOp(16'(3 + 11 * i), 16'sd17, 1'b1, 1'b0, 1'b0, 2'(i));
		waitIdle();
	endtask

	task automatic runInRangeProducts();
		int s, l;
		for (s = 0; s < 2; s++)
			for (l = 0; l < 4; l++)
				driveOp(s != 0 ? 16'(1000 + 3 * l) : 16'(50 + l), s != 0 ? 16'sd3000 : 16'sd60,
					1'b0, s[0], l[0], 2'(l));
		waitIdle();
		checkValue("flagWord", 64'(flagWord), 64'd0);
	endtask

	task automatic saturateIr();
		int i;
		clearFlags();
		driveOp(16'sd32767, 16'sd2, 1'b0, 1'b0, 1'b0, 2'd0);	// Above IR max
		driveOp(-16'sd300, 16'sd200, 1'b0, 1'b0, 1'b0, 2'd1);	// Below IR min
		driveOp(-16'sd300, 16'sd200, 1'b0, 1'b0, 1'b1, 2'd2);	// lm floor
		waitIdle();
		checkValue("flagWord[24]", 64'(flagWord[24]), 64'd1);
		checkValue("flagWord[23]", 64'(flagWord[23]), 64'd1);
		checkValue("flagWord[22]", 64'(flagWord[22]), 64'd1);
		checkValue("flagWord[31]", 64'(flagWord[31]), 64'd1);
		for (i = 0; i < 4097; i++)	// Past 2^42
			driveOp(16'sh8000, 16'sh8000, i != 0, 1'b1, 1'b0, 2'd0);
		waitIdle();
		checkValue("flagWord[30]", 64'(flagWord[30]), 64'd1);
		for (i = 0; i < 4097; i++)
			driveOp(16'sh8000, 16'sd32767, i != 0, 1'b1, 1'b0, 2'd1);
		waitIdle();
		checkValue("flagWord[26]", 64'(flagWord[26]), 64'd1);
	endtask

	task automatic clampColorAndZ();
		clearFlags();
		driveOp(-16'sd5, 16'sd7, 1'b0, 1'b0, 1'b0, 2'd0);		// Colour and Z to 0
		driveOp(16'sd100, 16'sd100, 1'b0, 1'b0, 1'b0, 2'd1);	// Colour to 255
		waitIdle();
		checkValue("flagWord", 64'(flagWord), 64'h0030_0000);	// No summary bit
		driveOp(16'sd32767, 16'sd32767, 1'b0, 1'b1, 1'b0, 2'd2);	// Z max, OTZ
		driveOp(-16'sd1000, 16'sd1000, 1'b0, 1'b1, 1'b0, 2'd2);
		waitIdle();
		checkValue("flagWord[18]", 64'(flagWord[18]), 64'd1);
		checkValue("flagWord[31]", 64'(flagWord[31]), 64'd1);
	endtask

	task automatic exerciseLane3();
		int i;
		clearFlags();
		driveOp(16'sd4096, 16'sd4096, 1'b0, 1'b0, 1'b0, 2'd3);	// IR0 exactly 4096
		waitIdle();
		checkValue("flagWord", 64'(flagWord), 64'd0);
		checkValue("resultIr0", 64'(resultIr0), 64'd4096);
		driveOp(16'sd4096, 16'sd4097, 1'b0, 1'b0, 1'b0, 2'd3);
		for (i = 0; i < 3; i++)
			driveOp(16'sh8000, 16'sh8000, 1'b1, 1'b0, 1'b0, 2'd3);
		waitIdle();
		checkValue("flagWord[16]", 64'(flagWord[16]), 64'd1);
		checkValue("flagWord[12]", 64'(flagWord[12]), 64'd1);
		clearFlags();
		for (i = 0; i < 3; i++)
			driveOp(16'sh8000, 16'sd32767, i != 0, 1'b0, 1'b0, 2'd3);
		waitIdle();
		checkValue("flagWord[15]", 64'(flagWord[15]), 64'd1);
		checkValue("resultIr0", 64'(resultIr0), 64'd0);
		driveOp(16'sd8192, 16'sd8192, 1'b0, 1'b0, 1'b0, 2'd0);	// SX2 over
		driveOp(-16'sd8192, 16'sd8193, 1'b0, 1'b0, 1'b0, 2'd1);	// SY2 under
		waitIdle();
		checkValue("flagWord[14]", 64'(flagWord[14]), 64'd1);
		checkValue("flagWord[13]", 64'(flagWord[13]), 64'd1);
		checkValue("resultScreen", 64'(resultScreen), 64'h400);
	endtask

	task automatic stickyAndRandomFlags();
		logic [15:0] ra, rb, ctl;
		int i;
		clearFlags();
		driveOp(16'sd32767, 16'sd2, 1'b0, 1'b0, 1'b0, 2'd0);
		driveOp(16'sd3, 16'sd4, 1'b0, 1'b0, 1'b0, 2'd1);	// Clean op keeps old bit
		waitIdle();
		checkValue("flagWord[24]", 64'(flagWord[24]), 64'd1);
		driveOp(16'sd32767, 16'sd2, 1'b0, 1'b0, 1'b0, 2'd1);
		@(posedge clk);
		#1;
		opValid   = 1'b0;
		flagClear = 1'b1;	// Same edge as the result
		waitIdle();
		checkValue("flagWord[24]", 64'(flagWord[24]), 64'd0);
		checkValue("flagWord[23]", 64'(flagWord[23]), 64'd1);
		for (i = 0; i < 200; i++) begin
			ra  = randomBits(16);
			rb  = randomBits(16);
			ctl = randomBits(5);
			driveOp(ra, rb, ctl[0], ctl[1], ctl[2], ctl[4:3]);
		end
		waitIdle();
		clearFlags();
	endtask

	initial begin
		rstN       = 1'b0;
		opValid    = 1'b0;
		opA        = '0;
		opB        = '0;
		accumulate = 1'b0;
		sf         = 1'b0;
		lm         = 1'b0;
		lane       = '0;
		flagClear  = 1'b0;
		refAcc     = 0;
		expFlags   = '0;
		checking   = 1'b0;
		clrAtEdge  = 1'b0;
		cyc        = 0;
		lfsr       = 16'd43687;
		repeat (8) @(posedge clk);
		#1;
		rstN     = 1'b1;
		checking = 1'b1;
		checkResetAndLatency();
		runInRangeProducts();
		saturateIr();
		clampColorAndZ();
		exerciseLane3();
		stickyAndRandomFlags();
		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/gteMacStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module gteMacStage (
	input  wire  clk,
	input  wire  rstN,
	input  wire  opValid,
	input  wire  signed [gtePkg::OperandW-1:0] opA,
	input  wire  signed [gtePkg::OperandW-1:0] opB,
	input  wire  accumulate,
	input  wire  sf,
	input  wire  lm,
	input  wire  [gtePkg::LaneW-1:0] lane,
	input  wire  flagClear,
	output logic resultValid,	// Two cycles after opValid
	output logic [gtePkg::IrW-1:0]     resultIr,
	output logic [gtePkg::ColorW-1:0]  resultColor,
	output logic [gtePkg::ZW-1:0]      resultZ,
	output logic [gtePkg::ScreenW-1:0] resultScreen,
	output logic [gtePkg::Ir0W-1:0]    resultIr0,
	output logic [31:0] flagWord
);

	// Accumulator to checker and limiter
	logic signed [gtePkg::MacW-1:0] macValue;
	logic macValid;
	logic macSf;
	logic macLm;
	logic [gtePkg::LaneW-1:0] macLane;

	// Checker flags
	logic AxPos, AxNeg, FPos, FNeg, G, H, B, C, D;

	// Limiter fields
	logic [gtePkg::IrW-1:0]     irRaw, irBound;
	logic [gtePkg::ColorW-1:0]  colorRaw, colorBound;
	logic [gtePkg::ZW-1:0]      zRaw, zBound;
	logic [gtePkg::ScreenW-1:0] screenRaw, screenBound;
	logic [gtePkg::Ir0W-1:0]    ir0Raw, ir0Bound;

	gteMacAccumulator gteMacAccumulator_i (
		.clk(clk), .rstN(rstN), .opValid(opValid), .opA(opA), .opB(opB),
		.accumulate(accumulate), .sf(sf), .lm(lm), .lane(lane),
		.macValue(macValue), .macValid(macValid), .macSf(macSf), .macLm(macLm),
		.macLane(macLane)
	);

	// Range checks and field extraction run side by side
	GTEOverflowFLAGS GTEOverflowFLAGS_i (
		.v(macValue), .sf(macSf), .lm(macLm),
		.AxPos(AxPos), .AxNeg(AxNeg), .FPos(FPos), .FNeg(FNeg),
		.G(G), .H(H), .B(B), .C(C), .D(D)
	);

	gteFieldLimiter gteFieldLimiter_i (
		.macValue(macValue), .sf(macSf), .lm(macLm),
		.irRaw(irRaw), .irBound(irBound), .colorRaw(colorRaw), .colorBound(colorBound),
		.zRaw(zRaw), .zBound(zBound), .screenRaw(screenRaw), .screenBound(screenBound),
		.ir0Raw(ir0Raw), .ir0Bound(ir0Bound)
	);

	gteFlagWriter gteFlagWriter_i (
		.clk(clk), .rstN(rstN), .macValid(macValid), .macLane(macLane),
		.flagClear(flagClear),
		.AxPos(AxPos), .AxNeg(AxNeg), .FPos(FPos), .FNeg(FNeg),
		.G(G), .H(H), .B(B), .C(C), .D(D),
		.irRaw(irRaw), .irBound(irBound), .colorRaw(colorRaw), .colorBound(colorBound),
		.zRaw(zRaw), .zBound(zBound), .screenRaw(screenRaw), .screenBound(screenBound),
		.ir0Raw(ir0Raw), .ir0Bound(ir0Bound),
		.resultValid(resultValid), .resultIr(resultIr), .resultColor(resultColor),
		.resultZ(resultZ), .resultScreen(resultScreen), .resultIr0(resultIr0),
		.flagWord(flagWord)
	);

endmodule

`default_nettype wire

// ==== rtl/gteFlagWriter.sv ====
`timescale 1ns/1ps
`default_nettype none

module gteFlagWriter (
	input  wire  clk,
	input  wire  rstN,
	input  wire  macValid,
	input  wire  [gtePkg::LaneW-1:0] macLane,
	input  wire  flagClear,	// Zero sticky flags on next edge
	input  wire  AxPos,
	input  wire  AxNeg,
	input  wire  FPos,
	input  wire  FNeg,
	input  wire  G,
	input  wire  H,
	input  wire  B,
	input  wire  C,
	input  wire  D,
	input  wire  [gtePkg::IrW-1:0]     irRaw,
	input  wire  [gtePkg::IrW-1:0]     irBound,
	input  wire  [gtePkg::ColorW-1:0]  colorRaw,
	input  wire  [gtePkg::ColorW-1:0]  colorBound,
	input  wire  [gtePkg::ZW-1:0]      zRaw,
	input  wire  [gtePkg::ZW-1:0]      zBound,
	input  wire  [gtePkg::ScreenW-1:0] screenRaw,
	input  wire  [gtePkg::ScreenW-1:0] screenBound,
	input  wire  [gtePkg::Ir0W-1:0]    ir0Raw,
	input  wire  [gtePkg::Ir0W-1:0]    ir0Bound,
	output logic resultValid,
	output logic [gtePkg::IrW-1:0]     resultIr,
	output logic [gtePkg::ColorW-1:0]  resultColor,
	output logic [gtePkg::ZW-1:0]      resultZ,
	output logic [gtePkg::ScreenW-1:0] resultScreen,
	output logic [gtePkg::Ir0W-1:0]    resultIr0,
	output logic [31:0] flagWord
);

	gtePkg::gteFlagWord flagReg;
	gtePkg::gteFlagWord flagNext;

	// --------------------------------------------------
	// Saturated or raw result fields
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (macValid) begin
			resultIr     <= B ? irBound : irRaw;
			resultColor  <= C ? colorBound : colorRaw;
			resultZ      <= D ? zBound : zRaw;
			resultScreen <= G ? screenBound : screenRaw;
			resultIr0    <= H ? ir0Bound : ir0Raw;
		end
	end

	// Sticky flag update, clear drops old bits only
	always_comb begin
		flagNext = flagClear ? '0 : flagReg;
		if (macValid) begin
			if (macLane == gtePkg::LaneMac0) begin
				flagNext.fields.mac0Pos |= FPos;
				flagNext.fields.mac0Neg |= FNeg;
				flagNext.fields.ir0Sat  |= H;
			end else begin
				flagNext.fields.macPos[macLane]   |= AxPos;	// Lane code is the vector index
				flagNext.fields.macNeg[macLane]   |= AxNeg;
				flagNext.fields.irSat[macLane]    |= B;
				flagNext.fields.colorSat[macLane] |= C;
				if (macLane == gtePkg::LaneMac1) flagNext.fields.sxSat  |= G;
				if (macLane == gtePkg::LaneMac2) flagNext.fields.sySat  |= G;
				if (macLane == gtePkg::LaneMac3) flagNext.fields.otzSat |= D;
			end
		end
		flagNext.fields.errorSum = |(flagNext.raw & gtePkg::FlagErrorMask);	// Not bit 22 or colour
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			resultValid <= 1'b0;
			flagReg     <= '0;
		end else begin
			resultValid <= macValid;	// Flags land with the result
			flagReg     <= flagNext;
		end
	end

	assign flagWord = flagReg.raw;

	// No divider in this lane
	assert property (@(posedge clk) disable iff (!rstN) !flagWord[gtePkg::FlagDivBit])
		else $error("gteFlagWriter: divide flag set");

endmodule

`default_nettype wire

// ==== rtl/gteFieldLimiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module gteFieldLimiter (
	input  wire  signed [gtePkg::MacW-1:0] macValue,
	input  wire  sf,	// Select bit 12 as field base
	input  wire  lm,	// IR floor at 0
	output logic [gtePkg::IrW-1:0]     irRaw,
	output logic [gtePkg::IrW-1:0]     irBound,
	output logic [gtePkg::ColorW-1:0]  colorRaw,
	output logic [gtePkg::ColorW-1:0]  colorBound,
	output logic [gtePkg::ZW-1:0]      zRaw,
	output logic [gtePkg::ZW-1:0]      zBound,
	output logic [gtePkg::ScreenW-1:0] screenRaw,
	output logic [gtePkg::ScreenW-1:0] screenBound,
	output logic [gtePkg::Ir0W-1:0]    ir0Raw,
	output logic [gtePkg::Ir0W-1:0]    ir0Bound
);

	logic sgn;
	logic [15:0] shifted;	// Value >> (sf * 12), low 16 bits

	assign sgn     = macValue[gtePkg::MacW-1];
	assign shifted = sf ? macValue[27:12] : macValue[15:0];

	// --------------------------------------------------
	// Raw slices
	// --------------------------------------------------
	assign irRaw     = shifted;
	assign zRaw      = shifted;
	assign colorRaw  = sf ? macValue[23:16] : macValue[11:4];	// Extra >> 4
	assign screenRaw = macValue[26:16];	// Always >> 16
	assign ir0Raw    = macValue[24:12];	// Always >> 12, 13 bits hold 4096

	// --------------------------------------------------
	// Bounds from sign alone
	// --------------------------------------------------
	// IR signed limits or 0 floor with lm
	always_comb begin
		if (!sgn)
			irBound = {1'b0, {(gtePkg::IrW-1){1'b1}}};
		else if (lm)
			irBound = '0;
		else
			irBound = {1'b1, {(gtePkg::IrW-1){1'b0}}};
	end

	assign colorBound  = sgn ? '0 : {gtePkg::ColorW{1'b1}};
	assign zBound      = sgn ? '0 : {gtePkg::ZW{1'b1}};
	assign screenBound = sgn ? {1'b1, {(gtePkg::ScreenW-1){1'b0}}}	// -0x400
		: {1'b0, {(gtePkg::ScreenW-1){1'b1}}};	// 0x3FF
	assign ir0Bound    = sgn ? '0 : {1'b1, {(gtePkg::Ir0W-1){1'b0}}};	// 0 or 0x1000

endmodule

`default_nettype wire

// ==== rtl/gteMacAccumulator.sv ====
`timescale 1ns/1ps
`default_nettype none

module gteMacAccumulator (
	input  wire  clk,
	input  wire  rstN,
	input  wire  opValid,	// One operation per high cycle
	input  wire  signed [gtePkg::OperandW-1:0] opA,
	input  wire  signed [gtePkg::OperandW-1:0] opB,
	input  wire  accumulate,	// Add product to previous value
	input  wire  sf,
	input  wire  lm,
	input  wire  [gtePkg::LaneW-1:0] lane,
	output logic signed [gtePkg::MacW-1:0] macValue,
	output logic macValid,
	output logic macSf,		// Controls aligned with macValue
	output logic macLm,
	output logic [gtePkg::LaneW-1:0] macLane
);

	logic signed [2*gtePkg::OperandW-1:0] product;
	logic signed [gtePkg::MacW-1:0] productExt;
	logic signed [gtePkg::MacW-1:0] accIn;
	logic signed [gtePkg::MacW-1:0] sum;

	assign product    = opA * opB;	// 32 bit signed product
	assign productExt = {{(gtePkg::MacW-2*gtePkg::OperandW){product[2*gtePkg::OperandW-1]}},
		product};
	assign accIn      = accumulate ? macValue : '0;	// Previous result, even one still in flight
	assign sum        = productExt + accIn;

	// Accumulator state
	always_ff @(posedge clk) begin
		if (!rstN) begin
			macValid <= 1'b0;
			macValue <= '0;
		end else begin
			macValid <= opValid;
			if (opValid) macValue <= sum;
		end
	end

	// Controls travel with the value
	always_ff @(posedge clk) begin
		if (opValid) begin
			macSf   <= sf;
			macLm   <= lm;
			macLane <= lane;
		end
	end

	// Every valid MAC output traces back to an accepted operation
	assert property (@(posedge clk) disable iff (!rstN) $rose(macValid) |-> $past(opValid))
		else $error("gteMacAccumulator: macValid rose without opValid");

endmodule

`default_nettype wire

// ==== rtl/GTEOverflowFLAGS.sv ====
`timescale 1ns/1ps
`default_nettype none

module GTEOverflowFLAGS (
	input  wire signed [gtePkg::MacW-1:0] v,	// Registered MAC value
	input  wire  sf,	// Fields start at bit 12 when set
	input  wire  lm,	// IR floor is 0 when set
	output logic AxPos,	// MAC1..3 too large
	output logic AxNeg,	// MAC1..3 too small
	output logic FPos,	// MAC0 too large
	output logic FNeg,	// MAC0 too small
	output logic G,		// Screen coordinate out of 11 bits
	output logic H,		// IR0 outside 0..4096
	output logic B,		// IR out of range
	output logic C,		// Colour out of 0..255
	output logic D		// Z out of 0..65535
);

	// A value is in range when every bit above the field equals the sign.
	// Positive side ORs the high bits, negative side ANDs them.
	logic sgn;
	logic isPos;
	logic or47to42, or47to31, or47to28, or47to27, or47to26;
	logic or47to24, or47to16, or47to15, or47to12;
	logic and47to42, and47to31, and47to27, and47to26, and47to15;
	logic is4096;
	logic bOver, bUnder;

	assign sgn   = v[gtePkg::MacW-1];
	assign isPos = !sgn;

	// --------------------------------------------------
	// Shared reduction chains, widest range first
	// --------------------------------------------------
	assign or47to42  = |v[47:42];				// A
	assign or47to31  = or47to42 | (|v[41:31]);	// F
	assign or47to28  = or47to31 | (|v[30:28]);	// D with sf
	assign or47to27  = or47to28 | v[27];		// B with sf
	assign or47to26  = or47to27 | v[26];		// G, field at 26:16
	assign or47to24  = or47to26 | (|v[25:24]);	// C with sf, H
	assign or47to16  = or47to24 | (|v[23:16]);	// D without sf
	assign or47to15  = or47to16 | v[15];		// B without sf
	assign or47to12  = or47to15 | (|v[14:12]);	// C without sf, field at 11:4

	assign and47to42 = &v[47:42];
	assign and47to31 = and47to42 & (&v[41:31]);
	assign and47to27 = and47to31 & (&v[30:27]);
	assign and47to26 = and47to27 & v[26];
	assign and47to15 = and47to26 & (&v[25:15]);

	// Exactly 0x1000 after the 12 bit shift is still legal for IR0
	assign is4096 = !or47to26 && !v[25] && v[24] && !(|v[23:12]);

	// IR limits move with sf
	assign bOver  = sf ? or47to27 : or47to15;
	assign bUnder = sf ? !and47to27 : !and47to15;

	// --------------------------------------------------
	// Flag outputs
	// --------------------------------------------------
	assign AxPos = isPos & or47to42;
	assign AxNeg = sgn & !and47to42;
	assign FPos  = isPos & or47to31;
	assign FNeg  = sgn & !and47to31;
	assign G     = isPos ? or47to26 : !and47to26;	// -0x400..0x3FF
	assign H     = sgn | (or47to24 & !is4096);		// Anything negative fails
	assign B     = isPos ? bOver : (lm | bUnder);	// With lm any negative clamps
	assign C     = sgn | (sf ? or47to24 : or47to12);
	assign D     = sgn | (sf ? or47to28 : or47to16);

	// Chains agree with plain signed compares, so a pair is never both high
	always_comb begin
		assert (AxPos == (v >= 49'sh400_0000_0000) && AxNeg == (v < -49'sh400_0000_0000)
			&& FPos == (v >= 49'sh0_8000_0000) && FNeg == (v < -49'sh0_8000_0000))
			else $error("GTEOverflowFLAGS: MAC range flags disagree with the value");
	end

endmodule

`default_nettype wire

// ==== rtl/gtePkg.sv ====
`default_nettype none

package gtePkg;

	// Datapath widths
	localparam int MacW     = 49;	// Accumulated MAC value
	localparam int OperandW = 16;	// Signed multiplier operands
	localparam int LaneW    = 2;

	// Lane codes, one per MAC channel
	localparam logic [LaneW-1:0] LaneMac1 = 2'd0;	// Vector X component
	localparam logic [LaneW-1:0] LaneMac2 = 2'd1;	// Vector Y component
	localparam logic [LaneW-1:0] LaneMac3 = 2'd2;	// Vector Z component
	localparam logic [LaneW-1:0] LaneMac0 = 2'd3;	// Scalar channel

	// Result field widths
	localparam int IrW     = 16;
	localparam int ColorW  = 8;
	localparam int ZW      = 16;
	localparam int ScreenW = 11;
	localparam int Ir0W    = 13;

	// --------------------------------------------------
	// FLAG word layout
	// --------------------------------------------------
	localparam int          FlagDivBit    = 17;	// Divider overflow, no divider here
	localparam logic [31:0] FlagErrorMask = 32'h7F87_E000;	// Bits 30..23 and 18..13

	// Ascending ranges so element 0 lands on the MAC1 / R bit
	typedef struct packed {
		logic        errorSum;	// 31
		logic [0:2]  macPos;	// 30..28
		logic [0:2]  macNeg;	// 27..25
		logic [0:2]  irSat;		// 24..22
		logic [0:2]  colorSat;	// 21..19
		logic        otzSat;	// 18
		logic        divOvf;	// 17
		logic        mac0Pos;	// 16
		logic        mac0Neg;	// 15
		logic        sxSat;		// 14
		logic        sySat;		// 13
		logic        ir0Sat;	// 12
		logic [11:0] reserved;
	} gteFlagFields;

	// Whole register for reads, field view for updates
	typedef union packed {
		logic [31:0]  raw;
		gteFlagFields fields;
	} gteFlagWord;

endpackage

`default_nettype wire
